//--- filelist.f
+incdir+verilog
verilog/ipod_pkg.sv
verilog/kbd_command_decoder.sv
verilog/speed_control.sv
verilog/sample_tick_gen.sv
verilog/flash_reader.sv
verilog/sample_sequencer.sv
verilog/hex_display.sv
verilog/ipod_top.sv
test/flash_model.sv
test/ipod_tb.sv

//--- Bender.yml
package:
  name: ipod

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ipod_pkg.sv
      - verilog/kbd_command_decoder.sv
      - verilog/speed_control.sv
      - verilog/sample_tick_gen.sv
      - verilog/flash_reader.sv
      - verilog/sample_sequencer.sv
      - verilog/hex_display.sv
      - verilog/ipod_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/flash_model.sv
      - test/ipod_tb.sv

//--- test/ipod_tb.sv
`timescale 1ns/100ps
`include "ipod_settings.svh"

module ipod_tb;

  localparam int NUM_TESTS    = 10;
  localparam int WAIT_LIMIT   = 5000;
  localparam int KIND_RESET   = 0;
  localparam int KIND_KEY     = 1;
  localparam int KIND_COMMAND = 2;
  localparam ipod_pkg::flash_addr_t LAST_WORD = `FLASH_LAST_WORD;

  logic                  CLK_50M = 1'b0;
  logic                  rst_n;
  logic [2:0]            key;
  logic [7:0]            kbd_ascii;
  logic                  kbd_valid;
  logic                  flash_read;
  ipod_pkg::flash_addr_t flash_address;
  logic                  flash_waitrequest;
  logic [31:0]           flash_readdata;
  logic                  flash_readdatavalid;
  ipod_pkg::sample_t     audio_sample;
  logic                  sample_strobe;
  ipod_pkg::seg_t        hex0;
  ipod_pkg::seg_t        hex1;
  ipod_pkg::seg_t        hex2;
  ipod_pkg::seg_t        hex3;
  ipod_pkg::seg_t        hex4;
  ipod_pkg::seg_t        hex5;
  int                    protocol_errors;

  // Stimulus table
  string              t_name[NUM_TESTS];
  int                 t_kind[NUM_TESTS];
  logic [7:0]         t_code0[NUM_TESTS];
  logic [7:0]         t_code1[NUM_TESTS];
  int                 t_presses[NUM_TESTS];
  ipod_pkg::divisor_t t_divisor[NUM_TESTS];
  int                 t_quiet[NUM_TESTS];
  int                 t_count[NUM_TESTS];
  ipod_pkg::sample_t  t_samples[NUM_TESTS][4];

  int table_size   = 0;
  int test_errors  = 0;
  int tests_failed = 0;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top dut_i (
    .CLK_50M (CLK_50M), .rst_n (rst_n), .key (key),
    .kbd_ascii (kbd_ascii), .kbd_valid (kbd_valid),
    .flash_read (flash_read), .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest), .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample (audio_sample), .sample_strobe (sample_strobe),
    .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3), .hex4 (hex4), .hex5 (hex5)
  );

  flash_model flash_model_i (
    .CLK_50M (CLK_50M), .rst_n (rst_n),
    .flash_read (flash_read), .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest), .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid), .protocol_errors (protocol_errors)
  );

  // Samples held by the flash model for a word address
  function automatic ipod_pkg::sample_t word_lo(input ipod_pkg::flash_addr_t addr);
    return addr[15:0];
  endfunction

  function automatic ipod_pkg::sample_t word_hi(input ipod_pkg::flash_addr_t addr);
    return ~addr[15:0] ^ {addr[22:16], 9'h000};
  endfunction

  // Active-low digit pattern back to {found, nibble}
  function automatic logic [4:0] seg_to_digit(input ipod_pkg::seg_t seg);
    case (seg)
      7'h40: return 5'h10;
      7'h79: return 5'h11;
      7'h24: return 5'h12;
      7'h30: return 5'h13;
      7'h19: return 5'h14;
      7'h12: return 5'h15;
      7'h02: return 5'h16;
      7'h78: return 5'h17;
      7'h00: return 5'h18;
      7'h10: return 5'h19;
      7'h08: return 5'h1A;
      7'h03: return 5'h1B;
      7'h46: return 5'h1C;
      7'h21: return 5'h1D;
      7'h06: return 5'h1E;
      7'h0E: return 5'h1F;
      default: return 5'h00;
    endcase
  endfunction

  task automatic add_test(input string name, input int kind, input logic [7:0] code0,
                          input logic [7:0] code1, input int presses,
                          input ipod_pkg::divisor_t divisor, input int quiet, input int count,
                          input ipod_pkg::sample_t s0, input ipod_pkg::sample_t s1,
                          input ipod_pkg::sample_t s2, input ipod_pkg::sample_t s3);
    t_name[table_size]       = name;
    t_kind[table_size]       = kind;
    t_code0[table_size]      = code0;
    t_code1[table_size]      = code1;
    t_presses[table_size]    = presses;
    t_divisor[table_size]    = divisor;
    t_quiet[table_size]      = quiet;
    t_count[table_size]      = count;
    t_samples[table_size][0] = s0;
    t_samples[table_size][1] = s1;
    t_samples[table_size][2] = s2;
    t_samples[table_size][3] = s3;
    table_size = table_size + 1;
  endtask

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic check_divisor(input string name, input ipod_pkg::divisor_t expected);
    ipod_pkg::seg_t     digits[5];
    ipod_pkg::divisor_t actual;
    logic [4:0]         decoded;
    int                 i;
    digits = '{hex0, hex1, hex2, hex3, hex4};
    actual = '0;
    for (i = 0; i < 5; i++)
    begin
      decoded = seg_to_digit(digits[i]);
      if (!decoded[4])
      begin
        $display("Test %s: hex%0d shows an unknown pattern %h", name, i, digits[i]);
        test_errors = test_errors + 1;
      end
      actual[i*4 +: 4] = decoded[3:0];
    end
    if (hex5 !== 7'h7F)
    begin
      $display("Test %s: hex5 is not blank, it shows %h", name, hex5);
      test_errors = test_errors + 1;
    end
    if (actual !== expected)
    begin
      $display("Fail %s: expected divisor %h, actual %h", name, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  task automatic check_sample(input string name, input int index,
                              input ipod_pkg::sample_t expected, input ipod_pkg::sample_t actual);
    if (actual !== expected)
    begin
      $display("Fail %s sample %0d: expected %h, actual %h", name, index, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  // ==========================================================================
  // Drivers and waits
  // ==========================================================================
  task automatic press_key(input logic [1:0] index);
    @(posedge CLK_50M);
    key <= ~(3'b001 << index);
    repeat (4) @(posedge CLK_50M);
    key <= 3'b111;
    repeat (4) @(posedge CLK_50M);
  endtask

  task automatic send_command(input logic [7:0] code);
    @(posedge CLK_50M);
    kbd_ascii <= code;
    kbd_valid <= 1'b1;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
  endtask

  task automatic wait_strobe(input int limit, output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit)
    begin
      @(negedge CLK_50M);
      seen   = sample_strobe;
      cycles = cycles + 1;
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    int i;
    for (i = 0; i < cycles; i++)
    begin
      @(negedge CLK_50M);
      if (sample_strobe)
      begin
        $display("Test %s: unexpected sample strobe %0d cycles into a quiet window", name, i);
        test_errors = test_errors + 1;
      end
    end
  endtask

  task automatic run_test(input int idx);
    logic seen;
    int   i;
    test_errors = 0;
    if (t_kind[idx] == KIND_RESET)
    begin
      expect_quiet(t_name[idx], t_quiet[idx]);
      check_divisor(t_name[idx], t_divisor[idx]);
    end
    else if (t_kind[idx] == KIND_KEY)
    begin
      for (i = 0; i < t_presses[idx]; i++)
        press_key(t_code0[idx][1:0]);
      @(negedge CLK_50M);
      check_divisor(t_name[idx], t_divisor[idx]);
    end
    else
    begin
      send_command(t_code0[idx]);
      if (t_code1[idx] != 8'h00)
        send_command(t_code1[idx]);
      if (t_quiet[idx] > 0)
        expect_quiet(t_name[idx], t_quiet[idx]);
      seen = 1'b1;
      i    = 0;
      while (seen && i < t_count[idx])
      begin
        wait_strobe(WAIT_LIMIT, seen);
        if (!seen)
        begin
          $display("Test %s: timed out waiting for sample %0d", t_name[idx], i);
          test_errors = test_errors + 1;
        end
        else
          check_sample(t_name[idx], i, t_samples[idx][i], audio_sample);
        i = i + 1;
      end
    end
    if (test_errors == 0)
      $display("Test %0d %s: ok", idx, t_name[idx]);
    else
    begin
      $display("Test %0d %s: %0d errors", idx, t_name[idx], test_errors);
      tests_failed = tests_failed + 1;
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial
  begin
    rst_n     = 1'b0;
    key       = 3'b111;
    kbd_ascii = 8'h00;
    kbd_valid = 1'b0;

    add_test("reset_defaults", KIND_RESET, 0, 0, 0, `DIVISOR_DEFAULT, 200, 0, 0, 0, 0, 0);
    add_test("speed_up_once", KIND_KEY, 0, 0, 1, `DIVISOR_DEFAULT - `DIVISOR_STEP,
             0, 0, 0, 0, 0, 0);
    add_test("slow_down_twice", KIND_KEY, 1, 0, 2, `DIVISOR_DEFAULT + `DIVISOR_STEP,
             0, 0, 0, 0, 0, 0);
    add_test("speed_reset", KIND_KEY, 2, 0, 1, `DIVISOR_DEFAULT, 0, 0, 0, 0, 0, 0);
    add_test("speed_up_to_min", KIND_KEY, 0, 0, 80, `DIVISOR_MIN, 0, 0, 0, 0, 0, 0);
    // Lower case e must act like E
    add_test("forward_play", KIND_COMMAND, `ASCII_E | `ASCII_CASE_BIT, 0, 0, 0, 0, 4,
             word_lo(0), word_hi(0), word_lo(1), word_hi(1));
    add_test("pause", KIND_COMMAND, `ASCII_D, 0, 0, 0, 2000, 0, 0, 0, 0, 0);
    add_test("resume", KIND_COMMAND, `ASCII_E, 0, 0, 0, 0, 2,
             word_lo(2), word_hi(2), 0, 0);
    add_test("reverse_restart", KIND_COMMAND, `ASCII_B, `ASCII_R, 0, 0, 0, 3,
             word_hi(LAST_WORD), word_lo(LAST_WORD), word_hi(LAST_WORD - 1), 0);
    add_test("forward_restart", KIND_COMMAND, `ASCII_F, `ASCII_R, 0, 0, 0, 2,
             word_lo(0), word_hi(0), 0, 0);

    repeat (2) @(posedge CLK_50M);
    rst_n <= 1'b1;

    for (int idx = 0; idx < table_size; idx++)
      run_test(idx);

    repeat (4) @(posedge CLK_50M);
    $display("Tests run %0d, passed %0d, failed %0d, flash protocol errors %0d",
             table_size, table_size - tests_failed, tests_failed, protocol_errors);
    if (tests_failed == 0 && protocol_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- test/flash_model.sv
`timescale 1ns/100ps

module flash_model (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  flash_read,
  input  ipod_pkg::flash_addr_t flash_address,
  output logic                  flash_waitrequest,
  output logic [31:0]           flash_readdata,
  output logic                  flash_readdatavalid,
  output int                    protocol_errors
);

  ipod_pkg::flash_addr_t prev_address;
  ipod_pkg::flash_addr_t data_address;
  logic                  waiting;
  logic                  busy;
  logic                  seeded = 1'b0;
  int unsigned           delay;
  int                    cycle_errors;

  // ==========================================================================
  // Slave side of the flash bus with data that follows the address
  // ==========================================================================
  always @(posedge CLK_50M or negedge rst_n)
  begin
    if (!seeded)
    begin
      void'($urandom(32'h9089));
      seeded = 1'b1;
    end
    if (!rst_n)
    begin
      flash_waitrequest   <= 1'b1;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
      prev_address        <= '0;
      data_address        <= '0;
      waiting             <= 1'b0;
      busy                <= 1'b0;
      delay               <= 0;
      protocol_errors     <= 0;
    end
    else
    begin
      cycle_errors = 0;
      flash_readdatavalid <= 1'b0;
      flash_waitrequest   <= ($urandom_range(1, 0) == 1);
      prev_address        <= flash_address;
      // Read seen last cycle but not taken
      waiting             <= flash_read && flash_waitrequest;

      if (waiting && !flash_read)
      begin
        $display("Flash model: flash_read dropped before the read was accepted at %0t", $time);
        cycle_errors = cycle_errors + 1;
      end
      if (waiting && flash_read && flash_address != prev_address)
      begin
        $display("Flash model: flash_address changed while a read was waiting at %0t", $time);
        cycle_errors = cycle_errors + 1;
      end
      if (flash_read && busy)
      begin
        $display("Flash model: a second read was issued before readdatavalid at %0t", $time);
        cycle_errors = cycle_errors + 1;
      end

      if (busy)
      begin
        if (delay <= 1)
        begin
          // lo holds the low address bits and hi their inverse with the upper bits mixed in
          flash_readdata      <= {~data_address[15:0] ^ {data_address[22:16], 9'h000},
                                  data_address[15:0]};
          flash_readdatavalid <= 1'b1;
          busy                <= 1'b0;
        end
        else
          delay <= delay - 1;
      end
      else if (flash_read && !flash_waitrequest)
      begin
        busy         <= 1'b1;
        delay        <= $urandom_range(8, 1);
        data_address <= flash_address;
      end

      protocol_errors <= protocol_errors + cycle_errors;
    end
  end

endmodule

//--- verilog/ipod_top.sv
`timescale 1ns/100ps

module ipod_top (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic [2:0]            key,
  input  logic [7:0]            kbd_ascii,
  input  logic                  kbd_valid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  logic [31:0]           flash_readdata,
  input  logic                  flash_readdatavalid,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_strobe,
  output ipod_pkg::seg_t        hex0,
  output ipod_pkg::seg_t        hex1,
  output ipod_pkg::seg_t        hex2,
  output ipod_pkg::seg_t        hex3,
  output ipod_pkg::seg_t        hex4,
  output ipod_pkg::seg_t        hex5
);

  logic                  play;
  logic                  reverse;
  logic                  restart;
  logic                  tick;
  logic                  fetch_req;
  logic                  word_valid;
  ipod_pkg::divisor_t    divisor;
  ipod_pkg::flash_addr_t fetch_addr;
  ipod_pkg::flash_word_u word;

  // ==========================================================================
  // User controls
  // ==========================================================================
  kbd_command_decoder kbd_command_decoder_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play      (play),
    .reverse   (reverse),
    .restart   (restart)
  );

  speed_control speed_control_i (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .key     (key),
    .divisor (divisor)
  );

  hex_display hex_display_i (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .divisor (divisor),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  // ==========================================================================
  // Playback path
  // ==========================================================================
  sample_tick_gen sample_tick_gen_i (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .play    (play),
    .divisor (divisor),
    .tick    (tick)
  );

  sample_sequencer sample_sequencer_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .tick          (tick),
    .reverse       (reverse),
    .restart       (restart),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .word_valid    (word_valid),
    .word          (word),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

  flash_reader flash_reader_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .fetch_req           (fetch_req),
    .fetch_addr          (fetch_addr),
    .word_valid          (word_valid),
    .word                (word),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

endmodule

//--- verilog/hex_display.sv
`timescale 1ns/100ps

module hex_display (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  ipod_pkg::divisor_t divisor,
  output ipod_pkg::seg_t     hex0,
  output ipod_pkg::seg_t     hex1,
  output ipod_pkg::seg_t     hex2,
  output ipod_pkg::seg_t     hex3,
  output ipod_pkg::seg_t     hex4,
  output ipod_pkg::seg_t     hex5
);

  localparam ipod_pkg::seg_t SEG_BLANK = 7'h7F;

  // Hex digit to active-low segments
  function automatic ipod_pkg::seg_t seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_decode = 7'h40;
      4'h1: seg_decode = 7'h79;
      4'h2: seg_decode = 7'h24;
      4'h3: seg_decode = 7'h30;
      4'h4: seg_decode = 7'h19;
      4'h5: seg_decode = 7'h12;
      4'h6: seg_decode = 7'h02;
      4'h7: seg_decode = 7'h78;
      4'h8: seg_decode = 7'h00;
      4'h9: seg_decode = 7'h10;
      4'hA: seg_decode = 7'h08;
      4'hB: seg_decode = 7'h03;
      4'hC: seg_decode = 7'h46;
      4'hD: seg_decode = 7'h21;
      4'hE: seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hex0 <= SEG_BLANK;
      hex1 <= SEG_BLANK;
      hex2 <= SEG_BLANK;
      hex3 <= SEG_BLANK;
      hex4 <= SEG_BLANK;
      hex5 <= SEG_BLANK;
    end
    else
    begin
      hex0 <= seg_decode(divisor[3:0]);
      hex1 <= seg_decode(divisor[7:4]);
      hex2 <= seg_decode(divisor[11:8]);
      hex3 <= seg_decode(divisor[15:12]);
      hex4 <= seg_decode(divisor[19:16]);
      // Unused digit
      hex5 <= SEG_BLANK;
    end
  end

endmodule

//--- verilog/sample_sequencer.sv
`timescale 1ns/100ps
`include "ipod_settings.svh"

module sample_sequencer (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  tick,
  input  logic                  reverse,
  input  logic                  restart,
  output logic                  fetch_req,
  output ipod_pkg::flash_addr_t fetch_addr,
  input  logic                  word_valid,
  input  ipod_pkg::flash_word_u word,
  output ipod_pkg::sample_t     audio_sample,
  output logic                  sample_strobe
);

  localparam ipod_pkg::flash_addr_t LAST_WORD = `FLASH_LAST_WORD;

  ipod_pkg::flash_addr_t addr;
  ipod_pkg::flash_addr_t next_addr;
  ipod_pkg::sample_t     half_sample;
  logic                  loaded;
  logic                  pending;
  logic                  stale;
  logic                  need_fetch;
  logic                  second_half;

  assign fetch_addr = addr;

  // Forward plays lo first, reverse plays hi first
  assign half_sample = (second_half ^ reverse) ? word.samples.hi : word.samples.lo;

  // Step and wrap by direction
  always_comb
  begin
    if (reverse)
      next_addr = (addr == '0) ? LAST_WORD : addr - 1'b1;
    else
      next_addr = (addr == LAST_WORD) ? '0 : addr + 1'b1;
  end

  // ==========================================================================
  // Playback control
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      addr          <= '0;
      loaded        <= 1'b0;
      pending       <= 1'b0;
      stale         <= 1'b0;
      need_fetch    <= 1'b1;
      second_half   <= 1'b0;
      fetch_req     <= 1'b0;
      audio_sample  <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      fetch_req     <= 1'b0;
      sample_strobe <= 1'b0;
      if (restart)
      begin
        addr        <= reverse ? LAST_WORD : '0;
        loaded      <= 1'b0;
        second_half <= 1'b0;
        need_fetch  <= 1'b1;
        // The old word of a read still in flight gets dropped
        pending     <= pending & ~word_valid;
        stale       <= pending & ~word_valid;
      end
      else
      begin
        if (word_valid)
        begin
          pending <= 1'b0;
          stale   <= 1'b0;
          if (!stale)
            loaded <= 1'b1;
        end

        // Ticks with no word loaded are skipped
        if (tick && loaded)
        begin
          audio_sample  <= half_sample;
          sample_strobe <= 1'b1;
          if (second_half)
          begin
            second_half <= 1'b0;
            loaded      <= 1'b0;
            addr        <= next_addr;
            need_fetch  <= 1'b1;
          end
          else
          begin
            second_half <= 1'b1;
          end
        end

        if (need_fetch && !pending)
        begin
          fetch_req  <= 1'b1;
          pending    <= 1'b1;
          need_fetch <= 1'b0;
        end
      end
    end
  end

endmodule

//--- verilog/flash_reader.sv
`timescale 1ns/100ps

module flash_reader (
  input  logic                  CLK_50M,
  input  logic                  rst_n,
  input  logic                  fetch_req,
  input  ipod_pkg::flash_addr_t fetch_addr,
  output logic                  word_valid,
  output ipod_pkg::flash_word_u word,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  logic [31:0]           flash_readdata,
  input  logic                  flash_readdatavalid
);

  localparam logic [1:0] ST_IDLE      = 2'd0;
  localparam logic [1:0] ST_REQUEST   = 2'd1;
  localparam logic [1:0] ST_WAIT_DATA = 2'd2;

  logic [1:0] state;

  // ==========================================================================
  // Read FSM
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      flash_read <= 1'b0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (fetch_req)
          begin
            flash_read <= 1'b1;
            state      <= ST_REQUEST;
          end
        end
        ST_REQUEST:
        begin
          // Read stays up until the slave takes it
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= ST_IDLE;
          end
        end
        default:
        begin
          flash_read <= 1'b0;
          state      <= ST_IDLE;
        end
      endcase
    end
  end

  // Address and data registers
  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_IDLE && fetch_req)
      flash_address <= fetch_addr;
    if (state == ST_WAIT_DATA && flash_readdatavalid)
      word.raw <= flash_readdata;
  end

endmodule

//--- verilog/sample_tick_gen.sv
`timescale 1ns/100ps

module sample_tick_gen (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  logic               play,
  input  ipod_pkg::divisor_t divisor,
  output logic               tick
);

  ipod_pkg::divisor_t count;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= '0;
      tick  <= 1'b0;
    end
    else if (!play)
    begin
      // Held at zero while paused
      count <= '0;
      tick  <= 1'b0;
    end
    else if (count >= divisor - 1'b1)
    begin
      // Also catches a divisor that just dropped below the count
      count <= '0;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count + 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

//--- verilog/speed_control.sv
`timescale 1ns/100ps
`include "ipod_settings.svh"

module speed_control (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  logic [2:0]         key,
  output ipod_pkg::divisor_t divisor
);

  localparam ipod_pkg::divisor_t DIV_DEFAULT = `DIVISOR_DEFAULT;
  localparam ipod_pkg::divisor_t DIV_STEP    = `DIVISOR_STEP;
  localparam ipod_pkg::divisor_t DIV_MIN     = `DIVISOR_MIN;
  localparam ipod_pkg::divisor_t DIV_MAX     = `DIVISOR_MAX;

  logic [2:0] key_meta;
  logic [2:0] key_sync;
  logic [2:0] key_prev;
  logic [2:0] key_press;

  // ==========================================================================
  // Key synchronizers where a pressed key reads as 1
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= 3'b000;
      key_sync <= 3'b000;
      key_prev <= 3'b000;
    end
    else
    begin
      key_meta <= ~key;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  // One step per press
  assign key_press = key_sync & ~key_prev;

  // ==========================================================================
  // Divisor register
  // ==========================================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      divisor <= DIV_DEFAULT;
    end
    else if (key_press[2])
    begin
      divisor <= DIV_DEFAULT;
    end
    else if (key_press[0])
    begin
      // Faster means fewer cycles per sample
      if (divisor <= DIV_MIN + DIV_STEP)
        divisor <= DIV_MIN;
      else
        divisor <= divisor - DIV_STEP;
    end
    else if (key_press[1])
    begin
      if (divisor >= DIV_MAX - DIV_STEP)
        divisor <= DIV_MAX;
      else
        divisor <= divisor + DIV_STEP;
    end
  end

endmodule

//--- verilog/kbd_command_decoder.sv
`timescale 1ns/100ps
`include "ipod_settings.svh"

module kbd_command_decoder (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_valid,
  output logic       play,
  output logic       reverse,
  output logic       restart
);

  logic [7:0] upper_ascii;

  // Clearing the case bit maps a..z onto A..Z
  assign upper_ascii = kbd_ascii & ~(`ASCII_CASE_BIT);

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play    <= 1'b0;
      reverse <= 1'b0;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_valid)
      begin
        case (upper_ascii)
          `ASCII_E: play    <= 1'b1;
          `ASCII_D: play    <= 1'b0;
          `ASCII_F: reverse <= 1'b0;
          `ASCII_B: reverse <= 1'b1;
          `ASCII_R: restart <= 1'b1;
          // Anything else is ignored
          default:  ;
        endcase
      end
    end
  end

endmodule

//--- verilog/ipod_pkg.sv
`include "ipod_settings.svh"

package ipod_pkg;

  // One audio sample
  typedef logic [15:0] sample_t;

  // Word address on the flash bus
  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;

  // Clock cycles per sample
  typedef logic [`DIVISOR_W-1:0] divisor_t;

  // Active-low segments in gfedcba order
  typedef logic [6:0] seg_t;

  // Two samples packed in one flash word
  typedef struct packed {
    sample_t hi;
    sample_t lo;
  } sample_pair_t;

  typedef union packed {
    logic [31:0]  raw;
    sample_pair_t samples;
  } flash_word_u;

endpackage

//--- verilog/ipod_settings.svh
`ifndef IPOD_SETTINGS_SVH
`define IPOD_SETTINGS_SVH

// ==========================================================================
// Flash geometry
// ==========================================================================
`define FLASH_ADDR_W      23
`define FLASH_LAST_WORD   23'h7FFFFF

// ==========================================================================
// Sample divisor in CLK_50M cycles per sample
// ==========================================================================
`define DIVISOR_W         20
// About 22 kHz
`define DIVISOR_DEFAULT   2272
`define DIVISOR_STEP      32
`define DIVISOR_MIN       64
`define DIVISOR_MAX       65504

// ==========================================================================
// Upper-case keyboard command characters
// ==========================================================================
`define ASCII_E           8'h45
`define ASCII_D           8'h44
`define ASCII_F           8'h46
`define ASCII_B           8'h42
`define ASCII_R           8'h52
// Set in lower case letters only
`define ASCII_CASE_BIT    8'h20

`endif
